// File: sources.f
+incdir+tb
src/xlat_pkg.sv
src/cmd_sequencer.sv
src/read_tracker.sv
src/slave_translator.sv
tb/tb_slave_translator.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f sources.f --top-module tb_slave_translator \
   -o tb_sim --Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST PASSED"; then
   exit 0
fi

echo "Pass line not found in the simulation output"
exit 1

// File: tb/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ----------------------------------------------------------------------
// Helpers
// ----------------------------------------------------------------------

// Xorshift with shifts 13, 17, 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] s;
   s = x;
   s = s ^ (s << 13);
   s = s ^ (s >> 17);
   s = s ^ (s << 5);
   return s;
endfunction

// Unwritten words hold a value that differs for every address
function automatic logic [xlat_pkg::data_w-1:0] fill_word(
   input logic [xlat_pkg::av_addr_w-1:0] waddr);
   return {waddr, 2'b01} ^ 32'h9e37_79b9;
endfunction

function automatic logic [xlat_pkg::av_addr_w-1:0] word_addr(
   input logic [xlat_pkg::uav_addr_w-1:0] addr);
   logic [xlat_pkg::uav_addr_w-1:0] shifted;
   shifted = addr >> xlat_pkg::word_shift;
   return shifted[xlat_pkg::av_addr_w-1:0];
endfunction

function automatic logic [xlat_pkg::data_w-1:0] shadow_word(
   input logic [xlat_pkg::av_addr_w-1:0] waddr);
   if (shadow_mem.exists(waddr)) begin
      return shadow_mem[waddr];
   end
   return fill_word(waddr);
endfunction

function automatic logic [xlat_pkg::data_w-1:0] bit_word(input logic b);
   logic [xlat_pkg::data_w-1:0] w;
   w    = '0;
   w[0] = b;
   return w;
endfunction

task automatic stop_run(input string reason);
   $display("%s", reason);
   $display("TEST FAILED");
   $fatal(1, "Run stopped at the first error");
endtask

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------

// Readdata only matters when readdatavalid is expected
task automatic compare_rsp(input string name, input xlat_pkg::uav_rsp_t got,
                           input xlat_pkg::uav_rsp_t exp);
   if (got.waitrequest !== exp.waitrequest || got.readdatavalid !== exp.readdatavalid ||
       (exp.readdatavalid && got.readdata !== exp.readdata)) begin
      stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
   end
endtask

task automatic compare_cmd(input string name, input xlat_pkg::av_cmd_t got,
                           input xlat_pkg::av_cmd_t exp);
   if (got !== exp) begin
      stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
   end
endtask

task automatic compare_data(input string name, input logic [xlat_pkg::data_w-1:0] got,
                            input logic [xlat_pkg::data_w-1:0] exp);
   if (got !== exp) begin
      stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
   end
endtask

// Slave command expected at counter value c of a request
function automatic xlat_pkg::av_cmd_t expected_cmd(input xlat_pkg::uav_req_t req,
                                                   input int c);
   xlat_pkg::av_cmd_t cmd;
   cmd.address         = word_addr(req.address);
   cmd.writedata       = req.writedata;
   cmd.writebyteenable = req.write ? req.byteenable : '0;
   cmd.read            = req.read && (c >= setup_cycles);
   cmd.write           = req.write && (c >= setup_cycles) &&
                         (c <= setup_cycles + write_wait_cycles);
   cmd.begintransfer   = (c == 0);
   return cmd;
endfunction

// ----------------------------------------------------------------------
// Bus transfers
// ----------------------------------------------------------------------

// Holds the request until accepted and checks every cycle on the way
task automatic run_request(input xlat_pkg::uav_req_t req);
   xlat_pkg::uav_rsp_t exp_rsp;
   int                 accept_at;
   int                 cnt;
   bit                 accepted;
   accept_at = req.write ? write_accept_idx : read_accept_idx;
   cnt       = 0;
   accepted  = 1'b0;
   @(posedge clk);
   #(drive_delay);
   uav_req = req;
   while (!accepted) begin
      @(negedge clk);
      exp_rsp             = '0;
      exp_rsp.waitrequest = (cnt != accept_at);
      compare_rsp("uav_rsp", uav_rsp, exp_rsp);
      compare_cmd("av_cmd", av_cmd, expected_cmd(req, cnt));
      compare_data("av_chipselect", bit_word(av_chipselect), bit_word(1'b1));
      if (!uav_rsp.waitrequest) begin
         accepted = 1'b1;
      end else if (cnt >= max_wait) begin
         stop_run("Waitrequest stayed high and the request was never accepted");
      end else begin
         cnt++;
         @(posedge clk);
      end
   end
   @(posedge clk);
   #(drive_delay);
   uav_req = '0;
endtask

task automatic write_word(input logic [xlat_pkg::uav_addr_w-1:0] addr,
                          input logic [xlat_pkg::data_w-1:0] data,
                          input logic [xlat_pkg::be_w-1:0] be);
   xlat_pkg::uav_req_t          req;
   logic [xlat_pkg::data_w-1:0] word;
   req            = '0;
   req.address    = addr;
   req.writedata  = data;
   req.byteenable = be;
   req.write      = 1'b1;
   run_request(req);
   word = shadow_word(word_addr(addr));
   for (int b = 0; b < xlat_pkg::be_w; b++) begin
      if (be[b]) begin
         word[b*8 +: 8] = data[b*8 +: 8];
      end
   end
   shadow_mem[word_addr(addr)] = word;
endtask

// Chipselect must stay up while the read is in flight
task automatic read_word(input logic [xlat_pkg::uav_addr_w-1:0] addr,
                         input logic [xlat_pkg::data_w-1:0] exp_data);
   xlat_pkg::uav_req_t req;
   int                 lat;
   req            = '0;
   req.address    = addr;
   req.byteenable = '1;
   req.read       = 1'b1;
   run_request(req);
   lat = 1;
   @(negedge clk);
   while (!uav_rsp.readdatavalid) begin
      compare_data("av_chipselect", bit_word(av_chipselect), bit_word(1'b1));
      if (lat >= max_wait) begin
         stop_run("Readdatavalid never arrived after an accepted read");
      end
      lat++;
      @(negedge clk);
   end
   if (lat != read_latency) begin
      stop_run($sformatf("Readdatavalid came %0d cycles after the accept, not %0d",
                         lat, read_latency));
   end
   compare_data("uav_rsp.readdata", uav_rsp.readdata, exp_data);
endtask

// ----------------------------------------------------------------------
// Directed tests
// ----------------------------------------------------------------------
task automatic check_reset_state();
   xlat_pkg::uav_rsp_t exp_rsp;
   exp_rsp             = '0;
   exp_rsp.waitrequest = 1'b1;
   @(negedge clk);
   compare_rsp("uav_rsp", uav_rsp, exp_rsp);
   compare_cmd("av_cmd", av_cmd, '0);
   compare_data("av_chipselect", bit_word(av_chipselect), bit_word(1'b0));
endtask

task automatic single_write();
   write_word(first_addr, first_data, first_be);
endtask

task automatic single_read();
   read_word(first_addr, shadow_word(word_addr(first_addr)));
endtask

task automatic random_traffic();
   logic [31:0]                     r;
   logic [xlat_pkg::uav_addr_w-1:0] addr;
   for (int i = 0; i < 20; i++) begin
      rng_state = xorshift32(rng_state);
      r         = rng_state;
      // Only 16 words so that reads land on written data
      addr = 32'h0004_0000 | (r & 32'h0000_003f);
      if (r[31]) begin
         rng_state = xorshift32(rng_state);
         write_word(addr, rng_state, r[11:8]);
      end else begin
         read_word(addr, shadow_word(word_addr(addr)));
      end
   end
endtask

task automatic chipselect_and_begin();
   logic [xlat_pkg::uav_addr_w-1:0] addr;
   addr = 32'h0000_2f40;
   // Idle bus with nothing in flight
   @(negedge clk);
   compare_data("av_chipselect", bit_word(av_chipselect), bit_word(1'b0));
   compare_cmd("av_cmd", av_cmd, '0);
   write_word(addr, 32'h1357_9bdf, 4'hf);
   read_word(addr, shadow_word(word_addr(addr)));
   read_word(addr + 32'h4, shadow_word(word_addr(addr + 32'h4)));
endtask

`endif

// File: tb/tb_slave_translator.sv
`timescale 1ns/1ps

module tb_slave_translator;

   // ----------------------------------------------------------------------
   // Timing configuration under test
   // ----------------------------------------------------------------------
   localparam int setup_cycles      = 1;
   localparam int read_wait_cycles  = 2;
   localparam int write_wait_cycles = 1;
   localparam int hold_cycles       = 1;
   localparam int read_latency      = 2;

   // Counter values of the accept cycle
   localparam int read_accept_idx  = setup_cycles + read_wait_cycles;
   localparam int write_accept_idx = setup_cycles + write_wait_cycles + hold_cycles;

   localparam int clk_period      = 20;
   localparam int drive_delay     = 2;
   localparam int reset_cycles    = 16;
   localparam int num_tests       = 5;
   localparam int cycles_per_test = 400;

   // Longest stall before a handshake counts as hung
   localparam int max_wait = 32;

   // Word written in the single write, read back in the single read
   localparam logic [31:0] first_addr = 32'h0000_1a2e;
   localparam logic [31:0] first_data = 32'hcafe_f00d;
   localparam logic [3:0]  first_be   = 4'b1011;

   logic                        clk;
   logic                        reset;
   xlat_pkg::uav_req_t          uav_req;
   xlat_pkg::uav_rsp_t          uav_rsp;
   xlat_pkg::av_cmd_t           av_cmd;
   logic                        av_chipselect;
   logic [xlat_pkg::data_w-1:0] av_readdata;

   // Slave storage, and the testbench's own record of what it should hold
   logic [xlat_pkg::data_w-1:0] slave_mem  [logic [xlat_pkg::av_addr_w-1:0]];
   logic [xlat_pkg::data_w-1:0] shadow_mem [logic [xlat_pkg::av_addr_w-1:0]];

   logic [31:0] rng_state;

   // Read return pipeline of the slave model
   logic [read_latency-1:0]     ret_valid = '0;
   logic [xlat_pkg::data_w-1:0] ret_data [read_latency];

`include "tb_checks.svh"

   slave_translator #(
      .SETUP_CYCLES      (setup_cycles),
      .READ_WAIT_CYCLES  (read_wait_cycles),
      .WRITE_WAIT_CYCLES (write_wait_cycles),
      .HOLD_CYCLES       (hold_cycles),
      .READ_LATENCY      (read_latency)
   ) DUT (
      .clk           (clk),
      .reset         (reset),
      .uav_req       (uav_req),
      .uav_rsp       (uav_rsp),
      .av_cmd        (av_cmd),
      .av_chipselect (av_chipselect),
      .av_readdata   (av_readdata)
   );

   // ----------------------------------------------------------------------
   // Behavioral fixed-timing slave
   // ----------------------------------------------------------------------
   function automatic logic [xlat_pkg::data_w-1:0] mem_word(
      input logic [xlat_pkg::av_addr_w-1:0] waddr);
      if (slave_mem.exists(waddr)) begin
         return slave_mem[waddr];
      end
      return fill_word(waddr);
   endfunction

   always @(posedge clk) begin : slave_model
      logic [xlat_pkg::data_w-1:0] word;
      if (reset) begin
         ret_valid <= '0;
      end else begin
         if (av_chipselect && av_cmd.write) begin
            word = mem_word(av_cmd.address);
            for (int b = 0; b < xlat_pkg::be_w; b++) begin
               if (av_cmd.writebyteenable[b]) begin
                  word[b*8 +: 8] = av_cmd.writedata[b*8 +: 8];
               end
            end
            slave_mem[av_cmd.address] = word;
         end
         // Data captured at the accept, presented read_latency cycles on
         ret_valid[0] <= av_chipselect && av_cmd.read && !uav_rsp.waitrequest;
         ret_data[0]  <= mem_word(av_cmd.address);
         for (int i = 1; i < read_latency; i++) begin
            ret_valid[i] <= ret_valid[i-1];
            ret_data[i]  <= ret_data[i-1];
         end
      end
   end

   assign av_readdata = ret_valid[read_latency-1] ? ret_data[read_latency-1] : '0;

   // ----------------------------------------------------------------------
   // Clock, watchdog and test sequence
   // ----------------------------------------------------------------------
   initial begin
      clk = 1'b0;
      forever begin
         #(clk_period / 2) clk = ~clk;
      end
   end

   initial begin
      #((reset_cycles + num_tests * cycles_per_test) * clk_period);
      stop_run("Watchdog timeout, the tests did not finish in time");
   end

   initial begin
      reset     = 1'b1;
      uav_req   = '0;
      rng_state = 32'he57ac75b;
      repeat (reset_cycles) @(posedge clk);
      #(drive_delay);
      reset = 1'b0;

      check_reset_state();
      single_write();
      single_read();
      random_traffic();
      chipselect_and_begin();

      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: src/slave_translator.sv
`timescale 1ns/1ps

module slave_translator #(
   parameter int SETUP_CYCLES      = 0,
   parameter int READ_WAIT_CYCLES  = 0,
   parameter int WRITE_WAIT_CYCLES = 0,
   parameter int HOLD_CYCLES       = 0,
   parameter int READ_LATENCY      = 1
) (
   input  logic                        clk,
   input  logic                        reset,

   // Fabric side
   input  xlat_pkg::uav_req_t          uav_req,
   output xlat_pkg::uav_rsp_t          uav_rsp,

   // Slave side
   output xlat_pkg::av_cmd_t           av_cmd,
   output logic                        av_chipselect,
   input  logic [xlat_pkg::data_w-1:0] av_readdata
);

   logic                        waitrequest;
   logic                        read_accept;
   logic                        readdatavalid;
   logic                        reads_pending;
   logic [xlat_pkg::data_w-1:0] rsp_data;

   // ----------------------------------------------------------------------
   // Command side
   // ----------------------------------------------------------------------
   cmd_sequencer #(
      .SETUP_CYCLES      (SETUP_CYCLES),
      .READ_WAIT_CYCLES  (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES (WRITE_WAIT_CYCLES),
      .HOLD_CYCLES       (HOLD_CYCLES)
   ) u_cmd_sequencer (
      .clk         (clk),
      .reset       (reset),
      .uav_req     (uav_req),
      .av_cmd      (av_cmd),
      .waitrequest (waitrequest),
      .read_accept (read_accept)
   );

   // ----------------------------------------------------------------------
   // Read return side
   // ----------------------------------------------------------------------
   read_tracker #(
      .READ_LATENCY (READ_LATENCY)
   ) u_read_tracker (
      .clk           (clk),
      .reset         (reset),
      .read_accept   (read_accept),
      .av_readdata   (av_readdata),
      .uav_rsp_data  (rsp_data),
      .readdatavalid (readdatavalid),
      .reads_pending (reads_pending)
   );

   // ----------------------------------------------------------------------
   // Chipselect and fabric response
   // ----------------------------------------------------------------------

   // Kept up while reads are still in flight to the slave
   assign av_chipselect = uav_req.read | uav_req.write | reads_pending;

   always_comb begin
      uav_rsp.readdata      = rsp_data;
      uav_rsp.readdatavalid = readdatavalid;
      uav_rsp.waitrequest   = waitrequest;
   end

endmodule

// File: src/read_tracker.sv
`timescale 1ns/1ps

module read_tracker #(
   parameter int READ_LATENCY = 1
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        read_accept,
   input  logic [xlat_pkg::data_w-1:0] av_readdata,
   output logic [xlat_pkg::data_w-1:0] uav_rsp_data,
   output logic                        readdatavalid,
   output logic                        reads_pending
);

   // ----------------------------------------------------------------------
   // Read-latency shift register
   // ----------------------------------------------------------------------

   // Stage i holds a read accepted i+1 cycles ago
   logic [READ_LATENCY-1:0] lat_shift;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         lat_shift <= '0;
      end else begin
         lat_shift[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            lat_shift[i] <= lat_shift[i-1];
         end
      end
   end

   // Last stage lines up with the slave's data
   assign readdatavalid = lat_shift[READ_LATENCY-1];

   // ----------------------------------------------------------------------
   // Pending reads
   // ----------------------------------------------------------------------

   // Any read that has not reached the last stage is still in flight
   always_comb begin
      reads_pending = 1'b0;
      for (int i = 0; i < READ_LATENCY - 1; i++) begin
         reads_pending = reads_pending | lat_shift[i];
      end
   end

   // ----------------------------------------------------------------------
   // Read data
   // ----------------------------------------------------------------------

   // Slave data is valid in the readdatavalid cycle, sent on unregistered
   assign uav_rsp_data = av_readdata;

endmodule

// File: src/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer #(
   parameter int SETUP_CYCLES      = 0,
   parameter int READ_WAIT_CYCLES  = 0,
   parameter int WRITE_WAIT_CYCLES = 0,
   parameter int HOLD_CYCLES       = 0
) (
   input  logic               clk,
   input  logic               reset,
   input  xlat_pkg::uav_req_t uav_req,
   output xlat_pkg::av_cmd_t  av_cmd,
   output logic               waitrequest,
   output logic               read_accept
);

   // ----------------------------------------------------------------------
   // Counter indices for each phase of a request
   // ----------------------------------------------------------------------

   // Read accepted once setup and read wait have passed
   localparam int read_sum  = SETUP_CYCLES + READ_WAIT_CYCLES;

   // Last cycle with the write strobe up
   localparam int write_sum = SETUP_CYCLES + WRITE_WAIT_CYCLES;

   // Write accepted after the data hold cycles
   localparam int hold_sum  = write_sum + HOLD_CYCLES;

   localparam logic [xlat_pkg::cnt_w-1:0] setup_idx = SETUP_CYCLES[xlat_pkg::cnt_w-1:0];
   localparam logic [xlat_pkg::cnt_w-1:0] read_idx  = read_sum[xlat_pkg::cnt_w-1:0];
   localparam logic [xlat_pkg::cnt_w-1:0] write_idx = write_sum[xlat_pkg::cnt_w-1:0];
   localparam logic [xlat_pkg::cnt_w-1:0] hold_idx  = hold_sum[xlat_pkg::cnt_w-1:0];

   logic [xlat_pkg::cnt_w-1:0] wait_cnt;
   logic                       reset_override;
   logic                       wait_read;
   logic                       wait_write;
   logic                       wait_gen;
   logic                       begin_done;
   logic                       req_active;

   assign req_active = uav_req.read | uav_req.write;

   // ----------------------------------------------------------------------
   // Wait-state counter
   // ----------------------------------------------------------------------

   // Counts the cycles of the current request, restarts after each accept
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wait_cnt       <= '0;
         reset_override <= 1'b1;
      end else begin
         reset_override <= 1'b0;
         if (!waitrequest || reset_override) begin
            wait_cnt <= '0;
         end else if (req_active) begin
            wait_cnt <= wait_cnt + 1'b1;
         end else begin
            wait_cnt <= '0;
         end
      end
   end

   // ----------------------------------------------------------------------
   // Waitrequest
   // ----------------------------------------------------------------------

   // Low only in the accept cycle of the active direction
   always_comb begin
      wait_read  = (wait_cnt != read_idx);
      wait_write = (wait_cnt != hold_idx);
      if (uav_req.write) begin
         wait_gen = wait_write;
      end else begin
         wait_gen = wait_read;
      end
   end

   // First cycle out of reset always stalls the fabric
   assign waitrequest = wait_gen | reset_override;

   assign read_accept = uav_req.read & ~waitrequest;

   // ----------------------------------------------------------------------
   // Begintransfer
   // ----------------------------------------------------------------------

   // Set once the first cycle of a request has stalled, so the pulse
   // does not repeat while the request waits
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         begin_done <= 1'b0;
      end else if (!waitrequest) begin
         begin_done <= 1'b0;
      end else if (av_cmd.begintransfer && !reset_override) begin
         begin_done <= 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // Command to the slave
   // ----------------------------------------------------------------------
   always_comb begin
      // Byte address to word address
      av_cmd.address   = uav_req.address[xlat_pkg::uav_addr_w-1:xlat_pkg::word_shift];
      av_cmd.writedata = uav_req.writedata;

      // Byte-enables only count on writes
      av_cmd.writebyteenable = {xlat_pkg::be_w{uav_req.write}} & uav_req.byteenable;

      // Read strobe from end of setup until accept
      av_cmd.read = uav_req.read && (wait_cnt >= setup_idx);

      // Write strobe drops before the hold cycles
      av_cmd.write = uav_req.write && (wait_cnt >= setup_idx) &&
                     (wait_cnt <= write_idx);

      av_cmd.begintransfer = req_active & ~begin_done;
   end

endmodule

// File: src/xlat_pkg.sv
package xlat_pkg;

   // ----------------------------------------------------------------------
   // Bus widths
   // ----------------------------------------------------------------------

   // Fabric side is byte addressed
   parameter int uav_addr_w = 32;

   // Slave side is word addressed
   parameter int av_addr_w  = 30;

   parameter int data_w     = 32;
   parameter int be_w       = 4;

   // Low byte-address bits dropped when forming the word address
   parameter int word_shift = 2;

   // Wide enough for the largest setup + wait + hold index
   parameter int cnt_w      = 4;

   // ----------------------------------------------------------------------
   // Fabric request, one word per request
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic [uav_addr_w-1:0] address;
      logic [data_w-1:0]     writedata;
      logic [be_w-1:0]       byteenable;
      logic                  read;
      logic                  write;
   } uav_req_t;

   // ----------------------------------------------------------------------
   // Command to the fixed-timing slave
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic [av_addr_w-1:0] address;
      logic [data_w-1:0]    writedata;
      logic [be_w-1:0]      writebyteenable;
      logic                 read;
      logic                 write;
      logic                 begintransfer;
   } av_cmd_t;

   // ----------------------------------------------------------------------
   // Response back to the fabric
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic [data_w-1:0] readdata;
      logic              readdatavalid;
      logic              waitrequest;
   } uav_rsp_t;

endpackage
